//--- verilog/cachePkg.sv
package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// Address split for a 16 KB cache with 16-byte lines

	localparam int AddrWidth    = 32;                                 // Requester and memory address
	localparam int DataWidth    = 32;                                 // Bus and word width
	localparam int OffsetWidth  = 4;                                  // Byte within line
	localparam int IndexWidth   = 8;                                  // Set select
	localparam int TagWidth     = AddrWidth - IndexWidth - OffsetWidth;
	localparam int NumSets      = 1 << IndexWidth;

	// Line geometry
	localparam int WordsPerLine = 4;
	localparam int WordSelWidth = $clog2(WordsPerLine);               // Address bits 3 and 2
	localparam int LineWidth    = WordsPerLine * DataWidth;

	// Requester address as seen by the tag and data arrays
	typedef struct packed {
		logic [TagWidth-1:0]    tag;
		logic [IndexWidth-1:0]  index;
		logic [OffsetWidth-1:0] offset;
	} addrFields_t;

	// Operation request codes, anything else is acked and ignored
	typedef enum logic [3:0] {
		OpInvalidateLine = 4'd3,
		OpInvalidateAll  = 4'd4
	} opCode_t;

endpackage

//--- verilog/tagLookupIf.sv
interface tagLookupIf
	import cachePkg::*;
#(
	parameter int NumWays = 4
);
	localparam int WayWidth = $clog2(NumWays);

	// Lookup address, held for the whole request
	logic [IndexWidth-1:0] index;
	logic [TagWidth-1:0]   tag;

	// Update strobes from the controller
	logic                  fillEn;          // Install tag in fillWay
	logic [WayWidth-1:0]   fillWay;
	logic                  touchEn;         // Mark touchWay most recently used
	logic [WayWidth-1:0]   touchWay;
	logic                  invLineEn;       // Drop the hitting way
	logic                  invAllEn;        // Clear set clearIndex
	logic [IndexWidth-1:0] clearIndex;

	// Combinational lookup result
	logic                  hit;
	logic [WayWidth-1:0]   hitWay;
	logic [WayWidth-1:0]   victimWay;

	modport ctrl (output index, tag, fillEn, fillWay, touchEn, touchWay, invLineEn, invAllEn,
		clearIndex, input hit, hitWay, victimWay);

	modport store (input index, tag, fillEn, fillWay, touchEn, touchWay, invLineEn, invAllEn,
		clearIndex, output hit, hitWay, victimWay);

endinterface

//--- verilog/lineAccessIf.sv
interface lineAccessIf
	import cachePkg::*;
#(
	parameter int NumWays = 4
);
	localparam int WayWidth = $clog2(NumWays);

	logic [IndexWidth-1:0]   index;         // Set
	logic [WayWidth-1:0]     way;
	logic [WordSelWidth-1:0] wordSel;       // Word within line
	logic                    wrEn;
	logic [DataWidth-1:0]    wrData;
	logic [DataWidth-1:0]    rdData;        // One cycle behind the address

	modport ctrl (output index, way, wordSel, wrEn, wrData, input rdData);

	modport store (input index, way, wordSel, wrEn, wrData, output rdData);

endinterface

//--- verilog/tagStore.sv
module tagStore
	import cachePkg::*;
#(
	parameter int NumWays = 4
)(
	input  logic      clk,
	input  logic      arstN,
	tagLookupIf.store tagBus
);
	localparam int WayWidth = $clog2(NumWays);

	// Per-set state, one bit per way
	logic [NumWays-1:0]  validBits [NumSets];
	logic [NumWays-1:0]  mruBits [NumSets];
	logic [TagWidth-1:0] tagMem [NumSets][NumWays];

	logic [NumWays-1:0]  setValid;
	logic [NumWays-1:0]  setMru;
	logic [NumWays-1:0]  nextMru;
	logic                touchAny;
	logic [WayWidth-1:0] touchSel;

	assign setValid = validBits[tagBus.index];
	assign setMru   = mruBits[tagBus.index];

	//////////////////////////////////////////////////////////////////////
	// Lookup

	// Scan downward so the lowest matching way wins
	always_comb
	begin
		tagBus.hit    = 1'b0;
		tagBus.hitWay = '0;
		for (int w = NumWays - 1; w >= 0; w--)
		begin
			if (setValid[w] && (tagMem[tagBus.index][w] == tagBus.tag))
			begin
				tagBus.hit    = 1'b1;
				tagBus.hitWay = WayWidth'(w);
			end
		end
	end

	// Victim choice
	always_comb
	begin
		tagBus.victimWay = '0;
		for (int w = NumWays - 1; w >= 0; w--)
		begin
			if (!setMru[w])
				tagBus.victimWay = WayWidth'(w);  // Lowest not recently used
		end
		// An empty way beats any MRU choice
		for (int w = NumWays - 1; w >= 0; w--)
		begin
			if (!setValid[w])
				tagBus.victimWay = WayWidth'(w);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// MRU update

	assign touchAny = tagBus.fillEn || tagBus.touchEn;               // Fill counts as a touch
	assign touchSel = tagBus.fillEn ? tagBus.fillWay : tagBus.touchWay;

	always_comb
	begin
		nextMru = setMru | (NumWays'(1) << touchSel);
		if (&nextMru)
			nextMru = NumWays'(1) << touchSel;                       // Saturated, keep only this way
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int s = 0; s < NumSets; s++)
			begin
				validBits[s] <= '0;
				mruBits[s]   <= '0;
			end
		end
		else if (tagBus.invAllEn)
		begin
			validBits[tagBus.clearIndex] <= '0;                     // Sweep, one set per cycle
			mruBits[tagBus.clearIndex]   <= '0;
		end
		else
		begin
			if (touchAny)
				mruBits[tagBus.index] <= nextMru;
			if (tagBus.fillEn)
				validBits[tagBus.index][tagBus.fillWay] <= 1'b1;
			else if (tagBus.invLineEn && tagBus.hit)
				validBits[tagBus.index][tagBus.hitWay] <= 1'b0;    // Miss on invalidate is a no-op
		end
	end

	// Tag written only when a line is installed
	always_ff @(posedge clk)
	begin
		if (tagBus.fillEn)
			tagMem[tagBus.index][tagBus.fillWay] <= tagBus.tag;
	end

endmodule

//--- verilog/lineStore.sv
module lineStore
	import cachePkg::*;
#(
	parameter int NumWays = 4
)(
	input  logic       clk,
	input  logic       arstN,
	lineAccessIf.store lineBus
);

	// Line data, meaningful only where the tag store has valid set
	logic [LineWidth-1:0] lineMem [NumSets][NumWays];

	logic [DataWidth-1:0] wordOut;

	// Word slice of the addressed line
	assign wordOut = lineMem[lineBus.index][lineBus.way][lineBus.wordSel * DataWidth +: DataWidth];

	// Single word write
	always_ff @(posedge clk)
	begin
		if (lineBus.wrEn)
			lineMem[lineBus.index][lineBus.way][lineBus.wordSel * DataWidth +: DataWidth]
				<= lineBus.wrData;
	end

	// Registered read port, old data on a same-cycle write
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			lineBus.rdData <= '0;
		else
			lineBus.rdData <= wordOut;
	end

endmodule

//--- verilog/cacheControl.sv
module cacheControl
	import cachePkg::*;
#(
	parameter int NumWays = 4
)(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 vmemRequest,
	input  logic                 vmemWe,
	input  logic [AddrWidth-1:0] vmemAddress,
	input  logic [DataWidth-1:0] vmemWrData,
	output logic [DataWidth-1:0] vmemRdData,
	output logic                 vmemAck,
	input  logic                 opRequest,
	input  opCode_t              operation,
	output logic                 memRequest,
	output logic                 memWe,
	output logic [AddrWidth-1:0] memAddress,
	output logic [DataWidth-1:0] memWrData,
	input  logic [DataWidth-1:0] memRdData,
	input  logic                 memAck,
	tagLookupIf.ctrl             tagBus,
	lineAccessIf.ctrl            lineBus
);
	localparam int WayWidth = $clog2(NumWays);

	typedef enum logic [3:0] {
		Idle, Lookup, HitRead, FillReq, FillWait, FillRelease,
		WriteReq, WriteRelease, Sweep, AckHold
	} ctrlState_t;

	ctrlState_t              state;
	logic                    isOp;          // Operation request, not a data access
	logic                    reqWe;
	logic [WordSelWidth-1:0] wordCnt;       // Fill word in flight
	logic [IndexWidth-1:0]   sweepIdx;
	addrFields_t             reqAddr;
	logic [DataWidth-1:0]    reqData;
	opCode_t                 opReg;
	logic [WayWidth-1:0]     wayReg;        // Way being filled
	logic [WordSelWidth-1:0] reqWord;
	logic                    lastWord;

	assign reqWord  = reqAddr.offset[OffsetWidth-1 -: WordSelWidth];
	assign lastWord = (wordCnt == WordSelWidth'(WordsPerLine - 1));

	// Memory side, full address for writes, line base plus word for fills
	assign memAddress = memWe ? reqAddr
		: {reqAddr.tag, reqAddr.index, wordCnt, {(OffsetWidth - WordSelWidth){1'b0}}};
	assign memWrData  = reqData;

	//////////////////////////////////////////////////////////////////////
	// Tag store and data array strobes

	assign tagBus.index      = reqAddr.index;
	assign tagBus.tag        = reqAddr.tag;
	assign tagBus.fillEn     = (state == FillRelease) && !memAck && lastWord;  // Line complete
	assign tagBus.fillWay    = wayReg;
	assign tagBus.touchEn    = (state == Lookup) && !isOp && tagBus.hit;       // Read or write hit
	assign tagBus.touchWay   = tagBus.hitWay;
	assign tagBus.invLineEn  = (state == Lookup) && isOp && (opReg == OpInvalidateLine);
	assign tagBus.invAllEn   = (state == Sweep);
	assign tagBus.clearIndex = sweepIdx;

	// Hit way straight from lookup so the read lands one cycle later
	assign lineBus.index   = reqAddr.index;
	assign lineBus.way     = (state == Lookup) ? tagBus.hitWay : wayReg;
	assign lineBus.wordSel = (state == FillWait) ? wordCnt : reqWord;
	assign lineBus.wrEn    = ((state == Lookup) && !isOp && reqWe && tagBus.hit)
		|| ((state == FillWait) && memAck);
	assign lineBus.wrData  = (state == FillWait) ? memRdData : reqData;

	//////////////////////////////////////////////////////////////////////
	// Controller FSM

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state      <= Idle;
			vmemAck    <= 1'b0;
			memRequest <= 1'b0;
			memWe      <= 1'b0;
			isOp       <= 1'b0;
			reqWe      <= 1'b0;
			wordCnt    <= '0;
			sweepIdx   <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (vmemRequest)
					begin
						isOp  <= 1'b0;
						reqWe <= vmemWe;
						state <= Lookup;
					end
					else if (opRequest)
					begin
						isOp  <= 1'b1;
						reqWe <= 1'b0;
						state <= Lookup;
					end
				end
				Lookup:
				begin
					if (isOp)
					begin
						case (opReg)
							OpInvalidateLine: state <= HitRead;  // Same ack timing as a hit
							OpInvalidateAll:
							begin
								sweepIdx <= '0;
								state    <= Sweep;
							end
							default: state <= AckHold;           // Unknown code, just ack
						endcase
					end
					else if (reqWe)
					begin
						memRequest <= 1'b1;                      // Write-through, always
						memWe      <= 1'b1;
						state      <= WriteReq;
					end
					else if (tagBus.hit)
						state <= HitRead;
					else
					begin
						wordCnt <= '0;
						state   <= FillReq;
					end
				end
				HitRead: state <= AckHold;
				FillReq:
				begin
					memRequest <= 1'b1;
					state      <= FillWait;
				end
				FillWait:
				begin
					if (memAck)
					begin
						memRequest <= 1'b0;
						state      <= FillRelease;
					end
				end
				FillRelease:
				begin
					if (!memAck)                                 // Memory done with this word
					begin
						if (lastWord)
							state <= AckHold;
						else
						begin
							wordCnt <= wordCnt + 1'b1;
							state   <= FillReq;
						end
					end
				end
				WriteReq:
				begin
					if (memAck)
					begin
						memRequest <= 1'b0;
						state      <= WriteRelease;
					end
				end
				WriteRelease:
				begin
					if (!memAck)
					begin
						memWe <= 1'b0;
						state <= AckHold;
					end
				end
				Sweep:
				begin
					sweepIdx <= sweepIdx + 1'b1;
					if (sweepIdx == IndexWidth'(NumSets - 1))
						state <= AckHold;
				end
				AckHold:
				begin
					if (!vmemAck)
						vmemAck <= 1'b1;
					else if (!vmemRequest && !opRequest)     // Requester let go
					begin
						vmemAck <= 1'b0;
						state   <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge clk)
	begin
		if (state == Idle)
		begin
			reqAddr <= vmemAddress;
			reqData <= vmemWrData;
			opReg   <= operation;
		end
		if (state == Lookup)
			wayReg <= tagBus.victimWay;
		if (state == HitRead)
			vmemRdData <= lineBus.rdData;
		else if ((state == FillWait) && memAck && (wordCnt == reqWord))
			vmemRdData <= memRdData;                             // Requested word on its way in
	end

endmodule

//--- verilog/l1Cache.sv
module l1Cache
	import cachePkg::*;
#(
	parameter int NumWays = 4
)(
	input  logic                 clk,
	input  logic                 arstN,
	// Requester side
	input  logic                 vmemRequest,
	input  logic                 vmemWe,
	input  logic [AddrWidth-1:0] vmemAddress,
	input  logic [DataWidth-1:0] vmemWrData,
	output logic [DataWidth-1:0] vmemRdData,
	output logic                 vmemAck,
	input  logic                 opRequest,
	input  opCode_t              operation,
	// Main memory side
	output logic                 memRequest,
	output logic                 memWe,
	output logic [AddrWidth-1:0] memAddress,
	output logic [DataWidth-1:0] memWrData,
	input  logic [DataWidth-1:0] memRdData,
	input  logic                 memAck
);

	tagLookupIf  #(.NumWays(NumWays)) tagBus ();
	lineAccessIf #(.NumWays(NumWays)) lineBus ();

	cacheControl #(.NumWays(NumWays)) control (
		.clk         (clk),
		.arstN       (arstN),
		.vmemRequest (vmemRequest),
		.vmemWe      (vmemWe),
		.vmemAddress (vmemAddress),
		.vmemWrData  (vmemWrData),
		.vmemRdData  (vmemRdData),
		.vmemAck     (vmemAck),
		.opRequest   (opRequest),
		.operation   (operation),
		.memRequest  (memRequest),
		.memWe       (memWe),
		.memAddress  (memAddress),
		.memWrData   (memWrData),
		.memRdData   (memRdData),
		.memAck      (memAck),
		.tagBus      (tagBus.ctrl),
		.lineBus     (lineBus.ctrl)
	);

	// Valid, tag and MRU per set
	tagStore #(.NumWays(NumWays)) tags (
		.clk    (clk),
		.arstN  (arstN),
		.tagBus (tagBus.store)
	);

	// Line data
	lineStore #(.NumWays(NumWays)) lines (
		.clk     (clk),
		.arstN   (arstN),
		.lineBus (lineBus.store)
	);

endmodule

//--- tb/tbClock.sv
module tbClock
#(
	parameter int ResetCycles = 10
)(
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HalfPeriod = 20;              // 40 ns clock

	initial
	begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	// Release just after an edge, clear of the DUT sampling point
	initial
	begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#2 arstN = 1'b1;
	end

endmodule

//--- tb/cacheChecker.sv
module cacheChecker
	import cachePkg::*;
#(
	parameter int NumRows = 1
)(
	input  logic                 clk,
	input  logic                 arstN,
	// DUT ports under watch
	input  logic                 vmemAck,
	input  logic [DataWidth-1:0] vmemRdData,
	input  logic                 memRequest,
	input  logic                 memWe,
	input  logic [AddrWidth-1:0] memAddress,
	input  logic [DataWidth-1:0] memWrData,
	input  logic                 memAck,
	// Table row in progress
	input  int                   rowIdx,
	input  logic [2:0]           rowKind,
	input  logic [AddrWidth-1:0] rowAddr,
	input  logic [DataWidth-1:0] rowData,
	input  logic                 rowExpHit,
	input  logic                 reportEn,
	output int                   errorCount,
	output int                   rowsChecked
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [2:0] KindRead    = 3'd0;
	localparam logic [2:0] KindWrite   = 3'd1;
	localparam logic [2:0] KindInvLine = 3'd2;
	localparam logic [2:0] KindInvAll  = 3'd3;

	logic [DataWidth-1:0] written [logic [AddrWidth-1:0]];   // Words stored by write rows
	int                   readCount;                         // Memory reads in this row
	int                   writeCount;
	logic                 ackPrev;
	logic                 memAckPrev;
	logic [AddrWidth-1:0] fillAddr;

	initial
	begin
		errorCount  = 0;
		rowsChecked = 0;
		readCount   = 0;
		writeCount  = 0;
		ackPrev     = 1'b0;
		memAckPrev  = 1'b0;
	end

	// Main memory contents as the requester should see them
	function automatic logic [DataWidth-1:0] modelWord(input logic [AddrWidth-1:0] addr);
		if (written.exists(addr))
			return written[addr];
		return addr ^ 32'hA5A5_0000;                         // Untouched word pattern
	endfunction

	task automatic flagError(input string msg);
		errorCount++;
		$display("ERR @%0t ns: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Row end, compare traffic and data

	task automatic finishRow();
		int                   expReads;
		int                   expWrites;
		int                   errBefore;
		string                kindName;
		logic [DataWidth-1:0] expData;
		errBefore = errorCount;
		expReads  = 0;
		expWrites = 0;
		case (rowKind)
			KindRead:
			begin
				kindName = rowExpHit ? "read hit" : "read miss";
				expReads = rowExpHit ? 0 : WordsPerLine;     // Miss fills the whole line
				expData  = modelWord(rowAddr);
				if (vmemRdData !== expData)
					flagError($sformatf("row %0d read %08h returned %08h, expected %08h",
						rowIdx, rowAddr, vmemRdData, expData));
			end
			KindWrite:
			begin
				kindName  = "write";
				expWrites = 1;
				written[rowAddr] = rowData;                  // Write-through lands in memory
			end
			KindInvLine: kindName = "invalidate line";
			KindInvAll:  kindName = "invalidate all";
			default:     kindName = "other op";
		endcase
		if (readCount != expReads)
			flagError($sformatf("row %0d made %0d memory reads, expected %0d",
				rowIdx, readCount, expReads));
		if (writeCount != expWrites)
			flagError($sformatf("row %0d made %0d memory writes, expected %0d",
				rowIdx, writeCount, expWrites));
		$display("Row %2d %-15s %08h  reads %0d writes %0d  %s", rowIdx, kindName, rowAddr,
			readCount, writeCount, (errorCount == errBefore) ? "ok" : "bad");
		rowsChecked++;
		readCount  = 0;
		writeCount = 0;
	endtask

	// Idle outputs once reset lets go
	always @(posedge arstN)
	begin
		if (vmemAck !== 1'b0 || memRequest !== 1'b0 || memWe !== 1'b0)
			flagError($sformatf("after reset vmemAck %b memRequest %b memWe %b, expected 0",
				vmemAck, memRequest, memWe));
	end

	// Sample on the edge, where every DUT output is settled
	always @(posedge clk)
	begin
		fillAddr = {rowAddr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}}
			+ AddrWidth'(4 * readCount);                     // Next word of the fill
		if (arstN && memAck && !memAckPrev)
		begin
			if (memWe)
			begin
				writeCount++;
				if (memAddress !== rowAddr || memWrData !== rowData)
					flagError($sformatf("row %0d memory write %08h=%08h, expected %08h=%08h",
						rowIdx, memAddress, memWrData, rowAddr, rowData));
			end
			else
			begin
				if (memAddress !== fillAddr)
					flagError($sformatf("row %0d memory read at %08h, expected %08h",
						rowIdx, memAddress, fillAddr));
				readCount++;
			end
		end
		if (arstN && vmemAck && !ackPrev)
			finishRow();
		memAckPrev = memAck;
		ackPrev    = vmemAck;
	end

	always @(posedge reportEn)
		$display("Checked %0d of %0d rows, %0d errors", rowsChecked, NumRows, errorCount);

endmodule

//--- tb/cacheTb.sv
module cacheTb
	import cachePkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [2:0] KindRead    = 3'd0;
	localparam logic [2:0] KindWrite   = 3'd1;
	localparam logic [2:0] KindInvLine = 3'd2;
	localparam logic [2:0] KindInvAll  = 3'd3;
	localparam logic [2:0] KindOtherOp = 3'd4;

	localparam int          NumRows    = 26;
	localparam int          CycleLimit = NumRows * (4 * 6 + 10) + 300;   // 300 covers the sweep
	localparam logic [31:0] Seed       = 32'h5311;
	localparam int          MaxLatency = 4;                              // Memory ack delay, cycles

	typedef struct packed {
		logic [2:0]  kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic        expHit;
	} stimRow_t;

	stimRow_t rowTable [$];

	logic clk;
	logic arstN;
	logic vmemRequest;
	logic vmemWe;
	logic [AddrWidth-1:0] vmemAddress;
	logic [DataWidth-1:0] vmemWrData;
	logic [DataWidth-1:0] vmemRdData;
	logic vmemAck;
	logic opRequest;
	opCode_t operation;
	logic memRequest;
	logic memWe;
	logic [AddrWidth-1:0] memAddress;
	logic [DataWidth-1:0] memWrData;
	logic [DataWidth-1:0] memRdData;
	logic memAck;

	// Row info shared with the checker
	int         rowIdx;
	logic [2:0] rowKind;
	logic [31:0] rowAddr;
	logic [31:0] rowData;
	logic       rowExpHit;
	logic       reportEn;
	int         errorCount;
	int         rowsChecked;
	int         cycles;

	logic [DataWidth-1:0] memWords [logic [AddrWidth-1:0]];   // Responder storage

	tbClock #(.ResetCycles(10)) clockGen (.clk(clk), .arstN(arstN));

	l1Cache #(.NumWays(4)) uut (
		.clk(clk), .arstN(arstN),
		.vmemRequest(vmemRequest), .vmemWe(vmemWe), .vmemAddress(vmemAddress),
		.vmemWrData(vmemWrData), .vmemRdData(vmemRdData), .vmemAck(vmemAck),
		.opRequest(opRequest), .operation(operation),
		.memRequest(memRequest), .memWe(memWe), .memAddress(memAddress),
		.memWrData(memWrData), .memRdData(memRdData), .memAck(memAck)
	);

	cacheChecker #(.NumRows(NumRows)) watch (
		.clk(clk), .arstN(arstN),
		.vmemAck(vmemAck), .vmemRdData(vmemRdData), .memRequest(memRequest), .memWe(memWe),
		.memAddress(memAddress), .memWrData(memWrData), .memAck(memAck),
		.rowIdx(rowIdx), .rowKind(rowKind), .rowAddr(rowAddr), .rowData(rowData),
		.rowExpHit(rowExpHit), .reportEn(reportEn),
		.errorCount(errorCount), .rowsChecked(rowsChecked)
	);

	task automatic addRow(input logic [2:0] kind, input logic [31:0] addr,
		input logic [31:0] data, input logic expHit);
		rowTable.push_back({kind, addr, data, expHit});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table, set 0x10 for the replacement rows

	task automatic buildTable();
		addRow(KindRead,    32'h0000_1104, '0, 1'b0);            // A fills way 0
		addRow(KindRead,    32'h0000_110C, '0, 1'b1);
		addRow(KindRead,    32'h0000_1100, '0, 1'b1);
		addRow(KindRead,    32'h0000_2100, '0, 1'b0);            // B
		addRow(KindRead,    32'h0000_3100, '0, 1'b0);            // C
		addRow(KindRead,    32'h0000_4100, '0, 1'b0);            // D, MRU saturates
		addRow(KindRead,    32'h0000_1100, '0, 1'b1);            // A touched again
		addRow(KindRead,    32'h0000_5108, '0, 1'b0);            // E evicts B
		addRow(KindRead,    32'h0000_2100, '0, 1'b0);            // B back, evicts C
		addRow(KindRead,    32'h0000_1100, '0, 1'b1);
		addRow(KindRead,    32'h0000_3100, '0, 1'b0);            // C evicts E
		addRow(KindWrite,   32'h0000_1104, 32'hDEAD_0001, 1'b1); // Write hit
		addRow(KindRead,    32'h0000_1104, '0, 1'b1);
		addRow(KindWrite,   32'h0000_7200, 32'hCAFE_0002, 1'b0); // No allocate
		addRow(KindRead,    32'h0000_7200, '0, 1'b0);
		addRow(KindRead,    32'h0000_7204, '0, 1'b1);
		addRow(KindInvLine, 32'h0000_4100, '0, 1'b0);            // Drop D
		addRow(KindRead,    32'h0000_3104, '0, 1'b1);            // C untouched
		addRow(KindRead,    32'h0000_4100, '0, 1'b0);
		addRow(KindOtherOp, 32'h0000_0000, '0, 1'b0);            // Code 7, ack only
		addRow(KindRead,    32'h0000_1100, '0, 1'b1);
		addRow(KindInvAll,  32'h0000_0000, '0, 1'b0);
		addRow(KindRead,    32'h0000_1100, '0, 1'b0);
		addRow(KindRead,    32'h0000_2100, '0, 1'b0);
		addRow(KindRead,    32'h0000_7204, '0, 1'b0);
		addRow(KindRead,    32'h0000_1108, '0, 1'b1);
	endtask

	// One four-phase exchange with the requester side
	task automatic applyRow(input int idx);
		stimRow_t row;
		row = rowTable[idx];
		@(posedge clk);
		#2;
		rowIdx      = idx;
		rowKind     = row.kind;
		rowAddr     = row.addr;
		rowData     = row.data;
		rowExpHit   = row.expHit;
		vmemAddress = row.addr;
		vmemWrData  = row.data;
		vmemWe      = (row.kind == KindWrite);
		case (row.kind)
			KindRead, KindWrite: vmemRequest = 1'b1;
			KindInvLine: operation = OpInvalidateLine;
			KindInvAll:  operation = OpInvalidateAll;
			default:     operation = opCode_t'(4'd7);
		endcase
		if (row.kind != KindRead && row.kind != KindWrite)
			opRequest = 1'b1;
		do @(posedge clk); while (!vmemAck);
		#2;
		vmemRequest = 1'b0;
		opRequest   = 1'b0;
		do @(posedge clk); while (vmemAck);
	endtask

	initial
	begin
		int r;
		vmemRequest = 1'b0;
		vmemWe      = 1'b0;
		vmemAddress = '0;
		vmemWrData  = '0;
		opRequest   = 1'b0;
		operation   = opCode_t'(4'd0);
		reportEn    = 1'b0;
		rowIdx      = 0;
		rowKind     = KindRead;
		rowAddr     = '0;
		rowData     = '0;
		rowExpHit   = 1'b0;
		buildTable();
		@(posedge arstN);
		repeat (2) @(posedge clk);
		for (r = 0; r < rowTable.size(); r++)
			applyRow(r);
		repeat (2) @(posedge clk);
		reportEn = 1'b1;
		@(posedge clk);                                          // Counts line goes out first
		if (errorCount == 0 && rowsChecked == NumRows)
			$display("Testbench passed");
		else
		begin
			if (rowsChecked != NumRows)
				$display("Only %0d of %0d rows completed", rowsChecked, NumRows);
			$display("Testbench failed");
		end
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory responder, random ack delay of 1 to MaxLatency cycles

	initial
	begin
		int unsigned delay;
		memAck    = 1'b0;
		memRdData = '0;
		void'($urandom(Seed));
		forever
		begin
			@(posedge clk);
			if (memRequest && !memAck)
			begin
				delay = $urandom_range(MaxLatency, 1);
				repeat (delay - 1) @(posedge clk);
				#2;
				if (memWe)
					memWords[memAddress] = memWrData;
				else if (memWords.exists(memAddress))
					memRdData = memWords[memAddress];
				else
					memRdData = memAddress ^ 32'hA5A5_0000;
				memAck = 1'b1;
				do @(posedge clk); while (memRequest);           // Hold until request drops
				#2 memAck = 1'b0;
			end
		end
	end

	// Run limit
	initial
	begin
		cycles = 0;
		while (cycles < CycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: row %0d got no acknowledge within %0d cycles", rowIdx, CycleLimit);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- project.f
verilog/cachePkg.sv
verilog/tagLookupIf.sv
verilog/lineAccessIf.sv
verilog/tagStore.sv
verilog/lineStore.sv
verilog/cacheControl.sv
verilog/l1Cache.sv
tb/tbClock.sv
tb/cacheChecker.sv
tb/cacheTb.sv
